/* files.f */
src/pma_txn_pkg.sv
src/pma_cfg_pkg.sv
src/pma_region_match.sv
src/pma_fifo.sv
src/pma_access_gate.sv
src/pma_top.sv
sim/pma_checker.sv
sim/pma_tb.sv

/* Makefile */
TOP := pma_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f files.f

# the error limit lets the testbench see a failed assertion and end with $fatal
sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f files.f
	./obj_dir/V$(TOP) +verilator+error+limit+100

clean:
	rm -rf obj_dir

/* sim/pma_tb.sv */
/*
 * PMA subsystem testbench
 * Drives LCG-chosen requests into pma_top under random output stalls,
 * predicts each result from the region table and the allow rules and
 * compares every output handshake in order. Also checks the minimum latency.
 */

`timescale 1ns/1ps
`default_nettype none

module pma_tb;

  import pma_txn_pkg::*;
  import pma_cfg_pkg::*;

  localparam int NUM_REGIONS   = 4;
  localparam int FIFO_DEPTH    = 4;
  localparam int NUM_TXN       = 400;
  localparam int TIMEOUT_CYCLES = 1000;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    pma_kind_e         kind;
    logic              allow;
    logic              main;
    logic              bufferable;
    logic              cacheable;
    logic              integrity;
    logic              have_match;
    logic              multi_match;
    logic [IDX_W-1:0]  match_idx;
  } exp_t;

  logic              clk;
  logic              rst_i;
  logic              req_valid_i;
  logic              req_ready_o;
  logic [ADDR_W-1:0] req_addr_i;
  pma_kind_e         req_kind_i;
  logic              req_misaligned_i;
  logic              req_dbg_i;
  logic              out_valid_o;
  logic              out_ready_i;
  logic [ADDR_W-1:0] out_addr_o;
  pma_kind_e         out_kind_o;
  logic              out_allow_o;
  logic              out_main_o;
  logic              out_bufferable_o;
  logic              out_cacheable_o;
  logic              out_integrity_o;
  logic              out_have_match_o;
  logic              out_multi_match_o;
  logic [IDX_W-1:0]  out_match_idx_o;

  exp_t        exp_q[$];
  exp_t        front;
  int          n_out = 0;
  logic        stall_en = 1'b0;
  logic [31:0] stim_state;
  logic [31:0] stall_state;
  logic [3:0]  stall_left;

  pma_top #(
    .PMA_NUM_REGIONS (NUM_REGIONS),
    .FIFO_DEPTH      (FIFO_DEPTH)
  ) UUT (
    .clk               (clk),
    .rst_i             (rst_i),
    .req_valid_i       (req_valid_i),
    .req_ready_o       (req_ready_o),
    .req_addr_i        (req_addr_i),
    .req_kind_i        (req_kind_i),
    .req_misaligned_i  (req_misaligned_i),
    .req_dbg_i         (req_dbg_i),
    .out_valid_o       (out_valid_o),
    .out_ready_i       (out_ready_i),
    .out_addr_o        (out_addr_o),
    .out_kind_o        (out_kind_o),
    .out_allow_o       (out_allow_o),
    .out_main_o        (out_main_o),
    .out_bufferable_o  (out_bufferable_o),
    .out_cacheable_o   (out_cacheable_o),
    .out_integrity_o   (out_integrity_o),
    .out_have_match_o  (out_have_match_o),
    .out_multi_match_o (out_multi_match_o),
    .out_match_idx_o   (out_match_idx_o)
  );

  bind pma_top pma_checker #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_checker (
    .clk          (clk),
    .rst_i        (rst_i),
    .req_valid_i  (req_valid_i),
    .req_ready_i  (req_ready_o),
    .m_valid_i    (m_valid),
    .out_valid_i  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .out_fields_i ({out_addr_o, out_kind_o, out_allow_o, out_main_o, out_bufferable_o,
                    out_cacheable_o, out_integrity_o, out_have_match_o,
                    out_multi_match_o, out_match_idx_o})
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // expected result straight from the region table and the allow rules
  function automatic exp_t model(input logic [ADDR_W-1:0] addr, input pma_kind_e kind,
                                 input logic mis, input logic dbg);
    exp_t e;
    int   hits;
    e = '0;
    hits = 0;
    e.addr = addr;
    e.kind = kind;
    e.main = PMA_DEFAULT_ATTR.main;
    e.bufferable = PMA_DEFAULT_ATTR.bufferable;
    e.cacheable = PMA_DEFAULT_ATTR.cacheable;
    e.integrity = PMA_DEFAULT_ATTR.integrity;
    for (int i = 0; i < NUM_REGIONS; i++) begin
      if ((addr & PMA_REGIONS[i].mask) == PMA_REGIONS[i].base) begin
        if (hits == 0) begin
          e.match_idx = IDX_W'(i);
          e.main = PMA_REGIONS[i].attr.main;
          e.bufferable = PMA_REGIONS[i].attr.bufferable;
          e.cacheable = PMA_REGIONS[i].attr.cacheable;
          e.integrity = PMA_REGIONS[i].attr.integrity;
        end
        hits++;
      end
    end
    e.have_match = hits > 0;
    e.multi_match = hits > 1;
    if (kind == EXEC) begin
      e.bufferable = 1'b0;
    end
    if (dbg && ((addr & DM_MASK) == DM_BASE)) begin
      e.allow = 1'b1;
      e.main = 1'b1;
    end else begin
      e.allow = e.main || (kind != EXEC && !mis);
    end
    return e;
  endfunction

  // each region, the overlap window, the debug module and unmapped space
  function automatic logic [ADDR_W-1:0] pick_addr(input logic [31:0] r);
    case (r[31:29])
      3'd0: return {16'h0000, r[15:2], 2'b00};
      3'd1: return {4'h2, r[27:2], 2'b00};
      3'd2: return {20'h20000, r[11:2], 2'b00};
      3'd3: return {4'h8, r[27:2], 2'b00};
      3'd4: return {20'h1A110, r[11:2], 2'b00};
      3'd5: return {4'h4, r[27:2], 2'b00};
      3'd6: return {16'h0001, r[15:2], 2'b00};
      default: return {4'hC, r[27:2], 2'b00};
    endcase
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_field(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    assert (exp_v == act_v) else begin
      abort_run($sformatf("[FAIL] t=%0t %s expected=%0h actual=%0h",
                          $time, name, exp_v, act_v));
    end
  endtask

  // called 2 ns after a rising edge, returns 2 ns after the accepting edge
  task automatic send_request(input logic [ADDR_W-1:0] addr, input pma_kind_e kind,
                              input logic mis, input logic dbg);
    int waited;
    waited = 0;
    req_valid_i = 1'b1;
    req_addr_i = addr;
    req_kind_i = kind;
    req_misaligned_i = mis;
    req_dbg_i = dbg;
    @(negedge clk);
    while (!req_ready_o) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        abort_run("timeout: req_ready_o stayed low");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    req_valid_i = 1'b0;
  endtask

  task automatic check_min_latency;
    int cycles;
    cycles = 0;
    send_request(32'h8000_0100, LOAD, 1'b0, 1'b0);
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        abort_run("timeout: out_valid_o never rose in the latency check");
      end
    end while (!out_valid_o);
    assert (cycles == 3) else begin
      abort_run($sformatf("[FAIL] t=%0t out_valid_o latency expected=3 actual=%0d",
                          $time, cycles));
    end
  endtask

  // output stalls: mostly ready, short single stalls, rare long ones that fill the pipe
  initial begin
    out_ready_i = 1'b1;
    stall_left = '0;
    stall_state = lcg_step(lcg_step(32'hb37c));
    forever begin
      @(posedge clk);
      #2;
      stall_state = lcg_step(stall_state);
      if (!stall_en) begin
        out_ready_i = 1'b1;
      end else if (stall_left != '0) begin
        out_ready_i = 1'b0;
        stall_left = stall_left - 4'd1;
      end else if (stall_state[31:28] == 4'd0) begin
        out_ready_i = 1'b0;
        stall_left = {1'b1, stall_state[27:25]};
      end else begin
        out_ready_i = stall_state[24:23] != 2'd0;
      end
    end
  end

  // sample both handshakes mid-cycle where all signals are settled
  initial begin
    forever begin
      @(negedge clk);
      if (UUT.u_checker.failed) begin
        abort_run("a handshake assertion in pma_checker failed");
      end
      if (!rst_i && req_valid_i && req_ready_o) begin
        exp_q.push_back(model(req_addr_i, req_kind_i, req_misaligned_i, req_dbg_i));
      end
      if (!rst_i && out_valid_o && out_ready_i) begin
        assert (exp_q.size() != 0) else begin
          abort_run("output handshake with no request outstanding");
        end
        front = exp_q.pop_front();
        check_field("out_addr_o", front.addr, out_addr_o);
        check_field("out_kind_o", 32'(front.kind), 32'(out_kind_o));
        check_field("out_allow_o", 32'(front.allow), 32'(out_allow_o));
        check_field("out_main_o", 32'(front.main), 32'(out_main_o));
        check_field("out_bufferable_o", 32'(front.bufferable), 32'(out_bufferable_o));
        check_field("out_cacheable_o", 32'(front.cacheable), 32'(out_cacheable_o));
        check_field("out_integrity_o", 32'(front.integrity), 32'(out_integrity_o));
        check_field("out_have_match_o", 32'(front.have_match), 32'(out_have_match_o));
        check_field("out_multi_match_o", 32'(front.multi_match), 32'(out_multi_match_o));
        check_field("out_match_idx_o", 32'(front.match_idx), 32'(out_match_idx_o));
        n_out++;
      end
    end
  end

  initial begin
    int waited;
    logic [31:0] r;
    rst_i = 1'b1;
    req_valid_i = 1'b0;
    req_addr_i = '0;
    req_kind_i = LOAD;
    req_misaligned_i = 1'b0;
    req_dbg_i = 1'b0;
    stim_state = 32'hb37c;
    repeat (4) @(posedge clk);
    #2;
    rst_i = 1'b0;
    check_min_latency();
    stall_en = 1'b1;
    @(posedge clk);
    #2;
    for (int n = 0; n < NUM_TXN; n++) begin
      stim_state = lcg_step(stim_state);
      r = stim_state;
      if (r[19:16] == 4'd0) begin
        repeat (int'(r[21:20]) + 1) begin
          @(posedge clk);
          #2;
        end
      end
      stim_state = lcg_step(stim_state);
      send_request(pick_addr(stim_state),
                   pma_kind_e'((r[25:24] == 2'd3) ? 2'd0 : r[25:24]),
                   r[28], r[30]);
    end
    waited = 0;
    while (n_out < NUM_TXN + 1) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        abort_run("timeout: not all results came out of the pipeline");
      end
      @(negedge clk);
    end
    // idle cycles after the last result, a duplicated one would show up here
    repeat (FIFO_DEPTH + 2) @(negedge clk);
    if (exp_q.size() == 0 && !out_valid_o) begin
      $display("test passed");
      $finish;
    end else begin
      abort_run("an extra result came out after the last request");
    end
  end

endmodule

`default_nettype wire

/* sim/pma_checker.sv */
/*
 * PMA handshake checker
 * Concurrent assertions on the external ports of pma_top: output
 * stability under stall, back-pressure depth and state after reset.
 */

`timescale 1ns/1ps
`default_nettype none

module pma_checker #(
  parameter int FIFO_DEPTH = 4
) (
  input wire logic clk,
  input wire logic rst_i,
  input wire logic req_valid_i,
  input wire logic req_ready_i,
  input wire logic m_valid_i,
  input wire logic out_valid_i,
  input wire logic out_ready_i,
  // all out_* fields of pma_top, concatenated
  input wire logic [pma_txn_pkg::ADDR_W+pma_txn_pkg::IDX_W+8:0] out_fields_i
);

  logic [7:0] held;
  logic       stable_fail = 1'b0;
  logic       depth_fail = 1'b0;
  logic       reset_fail = 1'b0;
  logic       failed;

  // transactions accepted at the input and not yet delivered
  always_ff @(posedge clk) begin
    if (rst_i) begin
      held <= '0;
    end else if ((req_valid_i && req_ready_i) && !(out_valid_i && out_ready_i)) begin
      held <= held + 8'd1;
    end else if (!(req_valid_i && req_ready_i) && (out_valid_i && out_ready_i)) begin
      held <= held - 8'd1;
    end
  end

  assign failed = stable_fail | depth_fail | reset_fail;

  a_stall_stable: assert property (@(posedge clk) disable iff (rst_i)
    (out_valid_i && !out_ready_i) |=> (out_valid_i && $stable(out_fields_i)))
    else begin
      $error("out_valid_o or an out_* field changed while stalled");
      stable_fail = 1'b1;
    end

  a_full_depth: assert property (@(posedge clk) disable iff (rst_i)
    !req_ready_i |-> (held == 8'(FIFO_DEPTH + 2)))
    else begin
      $error("req_ready_o low with %0d transactions held", held);
      depth_fail = 1'b1;
    end

  a_after_reset: assert property (@(posedge clk)
    rst_i |=> (!out_valid_i && !m_valid_i && req_ready_i))
    else begin
      $error("pipeline not empty in the cycle after reset");
      reset_fail = 1'b1;
    end

endmodule

`default_nettype wire

/* src/pma_top.sv */
/*
 * PMA checking subsystem
 * Region matcher, decoupling FIFO and access gate in a three-stage
 * valid/ready pipeline from core request to checked result.
 */

`timescale 1ns/1ps
`default_nettype none

module pma_top #(
  parameter int PMA_NUM_REGIONS = 4,
  parameter int FIFO_DEPTH      = 4
) (
  input  wire logic                           clk,
  input  wire logic                           rst_i,

  input  wire logic                           req_valid_i,
  output logic                                req_ready_o,
  input  wire logic [pma_txn_pkg::ADDR_W-1:0] req_addr_i,
  input  wire pma_txn_pkg::pma_kind_e         req_kind_i,
  input  wire logic                           req_misaligned_i,
  input  wire logic                           req_dbg_i,

  output logic                                out_valid_o,
  input  wire logic                           out_ready_i,
  output logic [pma_txn_pkg::ADDR_W-1:0]      out_addr_o,
  output pma_txn_pkg::pma_kind_e              out_kind_o,
  output logic                                out_allow_o,
  output logic                                out_main_o,
  output logic                                out_bufferable_o,
  output logic                                out_cacheable_o,
  output logic                                out_integrity_o,
  output logic                                out_have_match_o,
  output logic                                out_multi_match_o,
  output logic [pma_txn_pkg::IDX_W-1:0]       out_match_idx_o
);

  import pma_txn_pkg::*;

  // matcher to FIFO
  logic               m_valid;
  logic               m_ready;
  logic [ENTRY_W-1:0] m_entry;

  // FIFO to gate
  logic               f_valid;
  logic               f_ready;
  logic [ENTRY_W-1:0] f_entry;

  pma_region_match #(
    .NUM_REGIONS (PMA_NUM_REGIONS)
  ) u_match (
    .clk              (clk),
    .rst_i            (rst_i),
    .req_valid_i      (req_valid_i),
    .req_ready_o      (req_ready_o),
    .req_addr_i       (req_addr_i),
    .req_kind_i       (req_kind_i),
    .req_misaligned_i (req_misaligned_i),
    .req_dbg_i        (req_dbg_i),
    .out_valid_o      (m_valid),
    .out_ready_i      (m_ready),
    .out_entry_o      (m_entry)
  );

  pma_fifo #(
    .WIDTH (ENTRY_W),
    .DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk         (clk),
    .rst_i       (rst_i),
    .in_valid_i  (m_valid),
    .in_ready_o  (m_ready),
    .in_data_i   (m_entry),
    .out_valid_o (f_valid),
    .out_ready_i (f_ready),
    .out_data_o  (f_entry)
  );

  pma_access_gate u_gate (
    .clk               (clk),
    .rst_i             (rst_i),
    .in_valid_i        (f_valid),
    .in_ready_o        (f_ready),
    .in_entry_i        (f_entry),
    .out_valid_o       (out_valid_o),
    .out_ready_i       (out_ready_i),
    .out_addr_o        (out_addr_o),
    .out_kind_o        (out_kind_o),
    .out_allow_o       (out_allow_o),
    .out_main_o        (out_main_o),
    .out_bufferable_o  (out_bufferable_o),
    .out_cacheable_o   (out_cacheable_o),
    .out_integrity_o   (out_integrity_o),
    .out_have_match_o  (out_have_match_o),
    .out_multi_match_o (out_multi_match_o),
    .out_match_idx_o   (out_match_idx_o)
  );

endmodule

`default_nettype wire

/* src/pma_access_gate.sv */
/*
 * PMA access gate
 * Applies the allow rules to each looked-up entry and presents the
 * decision with the entry fields on a registered valid/ready port.
 */

`timescale 1ns/1ps
`default_nettype none

module pma_access_gate (
  input  wire logic                           clk,
  input  wire logic                           rst_i,

  input  wire logic                           in_valid_i,
  output logic                                in_ready_o,
  input  wire logic [pma_txn_pkg::ENTRY_W-1:0] in_entry_i,

  output logic                                out_valid_o,
  input  wire logic                           out_ready_i,
  output logic [pma_txn_pkg::ADDR_W-1:0]      out_addr_o,
  output pma_txn_pkg::pma_kind_e              out_kind_o,
  output logic                                out_allow_o,
  output logic                                out_main_o,
  output logic                                out_bufferable_o,
  output logic                                out_cacheable_o,
  output logic                                out_integrity_o,
  output logic                                out_have_match_o,
  output logic                                out_multi_match_o,
  output logic [pma_txn_pkg::IDX_W-1:0]       out_match_idx_o
);

  import pma_txn_pkg::*;

  pma_entry_t in_entry;
  logic       dbg_override;
  logic       allow;
  logic       main;

  assign in_entry = in_entry_i;

  // debug mode reaching the debug module bypasses the region attributes
  assign dbg_override = in_entry.dbg && in_entry.dmregion;

  always_comb begin
    main = in_entry.main;
    if (dbg_override) begin
      allow = 1'b1;
      main  = 1'b1;
    end else if (in_entry.kind == EXEC && !in_entry.main) begin
      allow = 1'b0;
    end else if (in_entry.misaligned && !in_entry.main) begin
      // io regions only take naturally aligned accesses
      allow = 1'b0;
    end else begin
      allow = 1'b1;
    end
  end

  assign in_ready_o = !out_valid_o || out_ready_i;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      out_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      out_valid_o <= in_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      out_addr_o        <= in_entry.addr;
      out_kind_o        <= in_entry.kind;
      out_allow_o       <= allow;
      out_main_o        <= main;
      out_bufferable_o  <= in_entry.bufferable;
      out_cacheable_o   <= in_entry.cacheable;
      out_integrity_o   <= in_entry.integrity;
      out_have_match_o  <= in_entry.have_match;
      out_multi_match_o <= in_entry.multi_match;
      out_match_idx_o   <= in_entry.match_idx;
    end
  end

endmodule

`default_nettype wire

/* src/pma_fifo.sv */
/*
 * Synchronous valid/ready FIFO
 * Circular buffer with read and write pointers and an occupancy count.
 * A write and a read can happen in the same cycle, also when full.
 */

`timescale 1ns/1ps
`default_nettype none

module pma_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  wire logic             clk,
  input  wire logic             rst_i,

  input  wire logic             in_valid_i,
  output logic                  in_ready_o,
  input  wire logic [WIDTH-1:0] in_data_i,

  output logic                  out_valid_o,
  input  wire logic             out_ready_i,
  output logic [WIDTH-1:0]      out_data_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             wr_en;
  logic             rd_en;

  assign full        = count == CNT_W'(DEPTH);
  assign out_valid_o = count != '0;
  // a read in the same cycle frees the slot for the write
  assign in_ready_o  = !full || out_ready_i;
  assign out_data_o  = mem[rd_ptr];

  assign wr_en = in_valid_i && in_ready_o;
  assign rd_en = out_valid_o && out_ready_i;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_data_i;
    end
  end

endmodule

`default_nettype wire

/* src/pma_region_match.sv */
/*
 * PMA region matcher
 * Compares each request address against the first NUM_REGIONS entries of
 * the region table, picks the lowest matching index and registers the
 * request together with the region attributes in a one-entry output stage.
 */

`timescale 1ns/1ps
`default_nettype none

module pma_region_match #(
  parameter int NUM_REGIONS = 4
) (
  input  wire logic                             clk,
  input  wire logic                             rst_i,

  input  wire logic                             req_valid_i,
  output logic                                  req_ready_o,
  input  wire logic [pma_txn_pkg::ADDR_W-1:0]   req_addr_i,
  input  wire pma_txn_pkg::pma_kind_e           req_kind_i,
  input  wire logic                             req_misaligned_i,
  input  wire logic                             req_dbg_i,

  output logic                                  out_valid_o,
  input  wire logic                             out_ready_i,
  output logic [pma_txn_pkg::ENTRY_W-1:0]       out_entry_o
);

  import pma_txn_pkg::*;
  import pma_cfg_pkg::*;

  if (NUM_REGIONS < 0 || NUM_REGIONS > PMA_MAX_REGIONS) begin : g_bad_num_regions
    $error("pma_region_match: NUM_REGIONS must be in 0..%0d", PMA_MAX_REGIONS);
  end

  logic [PMA_MAX_REGIONS-1:0] hit;
  logic [IDX_W-1:0]           win_idx;
  pma_attr_t                  win_attr;
  pma_entry_t                 next_entry;
  pma_entry_t                 stage_entry;
  logic                       stage_valid;

  // parallel compare, entries above NUM_REGIONS stay out of the lookup
  always_comb begin
    hit = '0;
    for (int i = 0; i < PMA_MAX_REGIONS; i++) begin
      if (i < NUM_REGIONS) begin
        hit[i] = (req_addr_i & PMA_REGIONS[i].mask) == PMA_REGIONS[i].base;
      end
    end
  end

  // walk downwards so the lowest index is the last one written
  always_comb begin
    win_idx  = '0;
    win_attr = PMA_DEFAULT_ATTR;
    for (int i = PMA_MAX_REGIONS - 1; i >= 0; i--) begin
      if (hit[i]) begin
        win_idx  = IDX_W'(i);
        win_attr = PMA_REGIONS[i].attr;
      end
    end
  end

  always_comb begin
    next_entry.addr        = req_addr_i;
    next_entry.kind        = req_kind_i;
    next_entry.misaligned  = req_misaligned_i;
    next_entry.dbg         = req_dbg_i;
    next_entry.have_match  = |hit;
    next_entry.multi_match = $countones(hit) > 1;
    next_entry.match_idx   = win_idx;
    next_entry.dmregion    = (req_addr_i & DM_MASK) == DM_BASE;
    next_entry.main        = win_attr.main;
    // instruction fetches are never bufferable
    next_entry.bufferable  = win_attr.bufferable && (req_kind_i != EXEC);
    next_entry.cacheable   = win_attr.cacheable;
    next_entry.integrity   = win_attr.integrity;
  end

  // stage takes a new request when empty or being drained this cycle
  assign req_ready_o = !stage_valid || out_ready_i;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      stage_valid <= 1'b0;
    end else if (req_ready_o) begin
      stage_valid <= req_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid_i && req_ready_o) begin
      stage_entry <= next_entry;
    end
  end

  assign out_valid_o = stage_valid;
  assign out_entry_o = stage_entry;

endmodule

`default_nettype wire

/* src/pma_cfg_pkg.sv */
/*
 * PMA configuration package
 * Fixed region table, attributes for unmatched addresses and the
 * address range of the debug module.
 */

`default_nettype none

package pma_cfg_pkg;

  import pma_txn_pkg::*;

  localparam int PMA_MAX_REGIONS = 16;

  typedef struct packed {
    logic main;
    logic bufferable;
    logic cacheable;
    logic integrity;
  } pma_attr_t;

  // region hits when (addr & mask) == base
  typedef struct packed {
    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] mask;
    pma_attr_t         attr;
  } pma_region_t;

  localparam pma_attr_t PMA_DEFAULT_ATTR = '{main: 1'b0, bufferable: 1'b0,
                                             cacheable: 1'b0, integrity: 1'b0};

  // base has a bit outside the mask, so this entry can never hit
  localparam pma_region_t PMA_UNUSED_REGION = '{base: 32'h0000_0001, mask: 32'h0000_0000,
                                                attr: PMA_DEFAULT_ATTR};

  localparam pma_region_t PMA_REGIONS [PMA_MAX_REGIONS] = '{
    // 64 KiB boot memory
    0: '{base: 32'h0000_0000, mask: 32'hFFFF_0000, attr: '{1'b1, 1'b0, 1'b1, 1'b1}},
    // peripheral space, io
    1: '{base: 32'h2000_0000, mask: 32'hF000_0000, attr: '{1'b0, 1'b1, 1'b0, 1'b0}},
    // scratch window inside the peripheral space, loses to entry 1
    2: '{base: 32'h2000_0000, mask: 32'hFFFF_F000, attr: '{1'b1, 1'b0, 1'b0, 1'b0}},
    // external memory
    3: '{base: 32'h8000_0000, mask: 32'hF000_0000, attr: '{1'b1, 1'b1, 1'b0, 1'b0}},
    default: PMA_UNUSED_REGION
  };

  // debug module, 4 KiB
  localparam logic [ADDR_W-1:0] DM_BASE = 32'h1A11_0000;
  localparam logic [ADDR_W-1:0] DM_MASK = 32'hFFFF_F000;

endpackage

`default_nettype wire

/* src/pma_txn_pkg.sv */
/*
 * PMA transaction package
 * Access-kind encoding, field widths and the packed layout of the entry
 * that travels from the region matcher through the FIFO to the access gate.
 */

`default_nettype none

package pma_txn_pkg;

  localparam int ADDR_W = 32;

  // wide enough to index a full region table
  localparam int IDX_W = 4;

  typedef enum logic [1:0] {
    LOAD  = 2'd0,
    STORE = 2'd1,
    EXEC  = 2'd2
  } pma_kind_e;

  // request fields first, lookup results after them
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    pma_kind_e         kind;
    logic              misaligned;
    logic              dbg;
    logic              have_match;
    logic              multi_match;
    logic [IDX_W-1:0]  match_idx;
    logic              dmregion;
    logic              main;
    logic              bufferable;
    logic              cacheable;
    logic              integrity;
  } pma_entry_t;

  localparam int ENTRY_W = $bits(pma_entry_t);

endpackage

`default_nettype wire
